// ==== verilog/cu_params.svh ====
`ifndef CU_PARAMS_SVH
`define CU_PARAMS_SVH

// instruction field widths
`define CU_OPCODE_W 6
`define CU_FUNCT_W 6

// opcode shared by every R-type instruction
`define CU_OP_RTYPE 6'd0

// FETCH is held this many cycles while memory answers
// must be at least 1
`define CU_FETCH_WAIT 2

`endif

// ==== verilog/cu_pkg.sv ====
`include "cu_params.svh"

package cu_pkg;

	typedef logic [`CU_OPCODE_W-1:0] opcode_t;
	typedef logic [`CU_FUNCT_W-1:0] funct_t;

	typedef enum logic [`CU_FUNCT_W-1:0] {
		FN_SLL   = 6'h00,
		FN_SRL   = 6'h02,
		FN_SRA   = 6'h03,
		FN_SLLV  = 6'h04,
		FN_XCH   = 6'h05,
		FN_SRAV  = 6'h07,
		FN_JR    = 6'h08,
		FN_BREAK = 6'h0D,
		FN_MFHI  = 6'h10,
		FN_MFLO  = 6'h12,
		FN_RTE   = 6'h13,
		FN_ADD   = 6'h20,
		FN_SUB   = 6'h22,
		FN_AND   = 6'h24,
		FN_SLT   = 6'h2A
	} funct_code_t;

	typedef enum logic [3:0] {
		CLS_ARITH, CLS_SHIFT, CLS_MFHI, CLS_MFLO, CLS_SLT,
		CLS_JR, CLS_RTE, CLS_BREAK, CLS_XCH, CLS_NONE
	} instr_class_t;

	typedef enum logic [2:0] {SK_SLL, SK_SRL, SK_SRA, SK_SLLV, SK_SRAV} shift_kind_t;

	typedef enum logic [7:0] {
		RESET       = 8'h00,
		FETCH       = 8'h01,
		FETCH_2     = 8'h02,
		DECODE      = 8'h03,
		ALU_EXEC    = 8'h04,
		SHIFT_LOAD  = 8'h07,
		MFHI        = 8'h0C,
		MFLO        = 8'h0D,
		SLT         = 8'h0E,
		JR          = 8'h0F,
		RTE         = 8'h10,
		BREAK       = 8'h11,
		XCH_1       = 8'h14,
		XCH_2       = 8'h15,
		WRITE_ARITH = 8'h85,
		SHIFT_RUN   = 8'h86,
		SHIFT_WRITE = 8'h87,
		FINAL       = 8'hFF
	} cu_state_t;

	// ALU function codes as the datapath ALU expects them
	typedef enum logic [2:0] {
		ALU_LOAD = 3'd0, ALU_ADD = 3'd1, ALU_SUB = 3'd2, ALU_AND = 3'd3, ALU_LESS = 3'd7
	} alu_op_t;

	typedef enum logic [1:0] {PC = 2'd0, REG_A = 2'd2} alu_a_sel_t;
	typedef enum logic [2:0] {REG_B = 3'd0, FOUR = 3'd1, OFFSET = 3'd4} alu_b_sel_t;
	typedef enum logic [2:0] {ALU_RESULT = 3'd0, EPC = 3'd2} pc_src_t;
	typedef enum logic [1:0] {RT = 2'd0, RS = 2'd1, RD = 2'd2, STACK_PTR = 2'd3} reg_dst_t;

	typedef enum logic [3:0] {
		ALU_OUT = 4'd0, HI = 4'd2, LO = 4'd3, SHIFTER = 4'd6, RESET_VALUE = 4'd7,
		XCH_REG = 4'd8, LT_FLAG = 4'd9, RT_VALUE = 4'd10
	} wb_src_t;

	typedef enum logic [2:0] {
		SH_HOLD, SH_LOAD, SH_LEFT, SH_RIGHT_LOGIC, SH_RIGHT_ARITH
	} shift_op_t;

	typedef enum logic {SHAMT_FIELD, RS_VALUE} shamt_sel_t;
	typedef enum logic {RT_IN, RT_ALT} shift_in_sel_t;

	typedef struct packed {
		alu_a_sel_t    alu_a;
		alu_b_sel_t    alu_b;
		alu_op_t       alu_op;
		pc_src_t       pc_src;
		reg_dst_t      reg_dst;
		wb_src_t       wb_src;
		shift_op_t     shift_op;
		shamt_sel_t    shamt_sel;
		shift_in_sel_t shift_in;
	} ctrl_sel_t;

	typedef struct packed {
		logic pc_write;
		logic ir_write;
		logic reg_write;
		logic a_load;
		logic b_load;
		logic alu_out_load;
		logic xch_load;
	} ctrl_en_t;

endpackage

// ==== verilog/instr_decoder.sv ====
`timescale 1ns/1ns
`include "cu_params.svh"

module instr_decoder import cu_pkg::*; (
	input  opcode_t      opcode,
	input  funct_t       funct,
	output instr_class_t instr_class,
	output shift_kind_t  shift_kind
);

	always_comb begin
		instr_class = CLS_NONE; // anything not listed does nothing
		shift_kind = SK_SLL;
		if (opcode == `CU_OP_RTYPE) begin
			case (funct)
				FN_ADD, FN_AND, FN_SUB: begin
					instr_class = CLS_ARITH;
				end
				FN_SLL: begin
					instr_class = CLS_SHIFT;
					shift_kind = SK_SLL;
				end
				FN_SRL: begin
					instr_class = CLS_SHIFT;
					shift_kind = SK_SRL;
				end
				FN_SRA: begin
					instr_class = CLS_SHIFT;
					shift_kind = SK_SRA;
				end
				FN_SLLV: begin
					instr_class = CLS_SHIFT;
					shift_kind = SK_SLLV; // amount from rs
				end
				FN_SRAV: begin
					instr_class = CLS_SHIFT;
					shift_kind = SK_SRAV; // amount from rs
				end
				FN_MFHI:  instr_class = CLS_MFHI;
				FN_MFLO:  instr_class = CLS_MFLO;
				FN_SLT:   instr_class = CLS_SLT;
				FN_JR:    instr_class = CLS_JR;
				FN_RTE:   instr_class = CLS_RTE;
				FN_BREAK: instr_class = CLS_BREAK;
				FN_XCH:   instr_class = CLS_XCH;
				default: begin
					instr_class = CLS_NONE; // unsupported R-type function
				end
			endcase
		end
	end

endmodule

// ==== verilog/cu_sequencer.sv ====
`timescale 1ns/1ns
`include "cu_params.svh"

module cu_sequencer import cu_pkg::*; (
	input  logic         clock,
	input  logic         reset,
	input  instr_class_t instr_class,
	output cu_state_t    state
);

	localparam int WAIT_W = $clog2(`CU_FETCH_WAIT + 1);

	cu_state_t next_state;
	logic [WAIT_W-1:0] wait_count; // cycles already spent in FETCH
	logic fetch_done;

	assign fetch_done = (wait_count == WAIT_W'(`CU_FETCH_WAIT - 1));

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= RESET;
			wait_count <= '0;
		end else begin
			state <= next_state;
			if (state == FETCH && !fetch_done) begin
				wait_count <= wait_count + 1'b1;
			end else begin
				wait_count <= '0; // also clears when leaving FETCH
			end
		end
	end

	always_comb begin
		next_state = RESET;
		case (state)
			RESET:   next_state = FETCH;
			FETCH:   next_state = fetch_done ? FETCH_2 : FETCH;
			FETCH_2: next_state = DECODE;
			DECODE: begin
				// only place the instruction class matters
				case (instr_class)
					CLS_ARITH: next_state = ALU_EXEC;
					CLS_SHIFT: next_state = SHIFT_LOAD;
					CLS_MFHI:  next_state = MFHI;
					CLS_MFLO:  next_state = MFLO;
					CLS_SLT:   next_state = SLT;
					CLS_JR:    next_state = JR;
					CLS_RTE:   next_state = RTE;
					CLS_BREAK: next_state = BREAK;
					CLS_XCH:   next_state = XCH_1;
					default:   next_state = FINAL;
				endcase
			end
			ALU_EXEC:   next_state = WRITE_ARITH;
			SHIFT_LOAD: next_state = SHIFT_RUN;
			SHIFT_RUN:  next_state = SHIFT_WRITE;
			XCH_1:      next_state = XCH_2;
			WRITE_ARITH, SHIFT_WRITE, MFHI, MFLO, SLT, JR, RTE, BREAK, XCH_2: begin
				next_state = FINAL;
			end
			FINAL:   next_state = FETCH;
			default: next_state = RESET; // recover from an illegal encoding
		endcase
	end

	a_state_legal: assert property (
		@(posedge clock) disable iff (reset)
		state inside {RESET, FETCH, FETCH_2, DECODE, ALU_EXEC, WRITE_ARITH,
			SHIFT_LOAD, SHIFT_RUN, SHIFT_WRITE, MFHI, MFLO, SLT, JR, RTE,
			BREAK, XCH_1, XCH_2, FINAL}
	) else $error("state left the declared encodings");

	a_wait_bound: assert property (
		@(posedge clock) disable iff (reset)
		wait_count < WAIT_W'(`CU_FETCH_WAIT)
	) else $error("fetch wait counter overran");

	// memory wait must always be served before the PC update
	a_fetch_order: assert property (
		@(posedge clock) disable iff (reset)
		(state == FETCH_2) |-> ($past(state) == FETCH)
	) else $error("FETCH_2 entered without FETCH");

endmodule

// ==== verilog/control_word_gen.sv ====
`timescale 1ns/1ns

module control_word_gen import cu_pkg::*; (
	input  logic        clock,
	input  cu_state_t   state,
	input  shift_kind_t shift_kind,
	input  funct_t      funct,
	output ctrl_sel_t   sel,
	output ctrl_en_t    en
);

	logic var_shift;

	// SLLV and SRAV take the amount from rs
	assign var_shift = (shift_kind == SK_SLLV) || (shift_kind == SK_SRAV);

	always_comb begin
		sel = '0;
		en = '0;
		case (state)
			RESET: begin
				en.reg_write = 1'b1; // stack pointer init
				sel.reg_dst = STACK_PTR;
				sel.wb_src = RESET_VALUE;
			end
			FETCH: begin
				en.ir_write = 1'b1;
				sel.alu_a = PC;
				sel.alu_b = FOUR;
				sel.alu_op = ALU_ADD; // pc + 4
			end
			FETCH_2: begin
				en.pc_write = 1'b1;
				sel.alu_a = PC;
				sel.alu_b = FOUR;
				sel.alu_op = ALU_ADD;
			end
			DECODE: begin
				en.a_load = 1'b1;
				en.b_load = 1'b1;
				en.alu_out_load = 1'b1; // branch target, speculative
				en.xch_load = 1'b1;
				sel.alu_a = PC;
				sel.alu_b = OFFSET;
				sel.alu_op = ALU_ADD;
			end
			ALU_EXEC: begin
				en.alu_out_load = 1'b1;
				sel.alu_a = REG_A;
				sel.alu_b = REG_B;
				case (funct)
					FN_AND:  sel.alu_op = ALU_AND;
					FN_SUB:  sel.alu_op = ALU_SUB;
					default: sel.alu_op = ALU_ADD;
				endcase
			end
			WRITE_ARITH: begin
				en.reg_write = 1'b1;
				sel.reg_dst = RD;
				sel.wb_src = ALU_OUT;
			end
			SHIFT_LOAD: begin
				sel.shift_op = SH_LOAD;
				if (var_shift) begin
					sel.shamt_sel = RS_VALUE;
					sel.shift_in = RT_ALT;
				end
			end
			SHIFT_RUN: begin
				if (var_shift) begin
					sel.shamt_sel = RS_VALUE;
					sel.shift_in = RT_ALT;
				end
				case (shift_kind)
					SK_SLL, SK_SLLV: sel.shift_op = SH_LEFT;
					SK_SRL:          sel.shift_op = SH_RIGHT_LOGIC;
					default:         sel.shift_op = SH_RIGHT_ARITH;
				endcase
			end
			SHIFT_WRITE: begin
				en.reg_write = 1'b1;
				sel.reg_dst = RD;
				sel.wb_src = SHIFTER;
			end
			MFHI: begin
				en.reg_write = 1'b1;
				sel.reg_dst = RD;
				sel.wb_src = HI;
			end
			MFLO: begin
				en.reg_write = 1'b1;
				sel.reg_dst = RD;
				sel.wb_src = LO;
			end
			SLT: begin
				en.reg_write = 1'b1;
				sel.reg_dst = RD;
				sel.wb_src = LT_FLAG; // sign-extended less flag
				sel.alu_a = REG_A;
				sel.alu_b = REG_B;
				sel.alu_op = ALU_LESS;
			end
			JR: begin
				en.pc_write = 1'b1;
				sel.alu_a = REG_A;
				sel.alu_op = ALU_LOAD; // pass rs through
			end
			RTE: begin
				en.pc_write = 1'b1;
				sel.pc_src = EPC;
			end
			BREAK: begin
				en.pc_write = 1'b1;
				sel.alu_a = PC;
				sel.alu_b = FOUR;
				sel.alu_op = ALU_SUB; // pc - 4
			end
			XCH_1: begin
				en.reg_write = 1'b1;
				sel.reg_dst = RS;
				sel.wb_src = RT_VALUE;
			end
			XCH_2: begin
				en.reg_write = 1'b1;
				sel.reg_dst = RT;
				sel.wb_src = XCH_REG; // old rs saved in DECODE
			end
			default: begin
				sel = '0; // FINAL and anything else
			end
		endcase
	end

	a_pc_ir_excl: assert property (
		@(posedge clock) !(en.pc_write && en.ir_write)
	) else $error("pc_write and ir_write active together");

	a_reg_pc_excl: assert property (
		@(posedge clock) !(en.reg_write && en.pc_write)
	) else $error("reg_write and pc_write active together");

endmodule

// ==== verilog/control_unit.sv ====
`timescale 1ns/1ns

module control_unit import cu_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	input  opcode_t   opcode,
	input  funct_t    funct,
	output ctrl_sel_t sel,
	output ctrl_en_t  en,
	output cu_state_t state
);

	instr_class_t instr_class;
	shift_kind_t shift_kind;

	instr_decoder i_decoder (
		.opcode      (opcode),
		.funct       (funct),
		.instr_class (instr_class),
		.shift_kind  (shift_kind)
	);

	cu_sequencer i_sequencer (
		.clock       (clock),
		.reset       (reset),
		.instr_class (instr_class),
		.state       (state)
	);

	control_word_gen i_word_gen (
		.clock      (clock),
		.state      (state),
		.shift_kind (shift_kind),
		.funct      (funct),
		.sel        (sel),
		.en         (en)
	);

endmodule

// ==== sim/tb_control_unit.sv ====
`timescale 1ns/1ns
`include "cu_params.svh"

module tb_control_unit import cu_pkg::*; ();

	// 18 instructions of at most 8 cycles plus reset is about 150 cycles
	localparam int TIMEOUT_CYCLES = 200;

	logic clock;
	logic reset;
	opcode_t opcode;
	funct_t funct;
	ctrl_sel_t sel;
	ctrl_en_t en;
	cu_state_t state;

	int cycle = 0;
	int errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	integer seed = 32'hb5b0c99c;

	control_unit i_dut (
		.clock  (clock),
		.reset  (reset),
		.opcode (opcode),
		.funct  (funct),
		.sel    (sel),
		.en     (en),
		.state  (state)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	always @(posedge clock) begin
		cycle <= cycle + 1;
		if (cycle >= TIMEOUT_CYCLES) begin
			$display("run timed out after %0d cycles", cycle);
			$display("Test failures found");
			$finish;
		end
	end

	function automatic instr_class_t class_of(opcode_t op, funct_t fn);
		instr_class_t cls;
		cls = CLS_NONE; // non R-type opcodes do nothing
		if (op == `CU_OP_RTYPE) begin
			case (fn)
				FN_ADD, FN_AND, FN_SUB: cls = CLS_ARITH;
				FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRAV: cls = CLS_SHIFT;
				FN_MFHI:  cls = CLS_MFHI;
				FN_MFLO:  cls = CLS_MFLO;
				FN_SLT:   cls = CLS_SLT;
				FN_JR:    cls = CLS_JR;
				FN_RTE:   cls = CLS_RTE;
				FN_BREAK: cls = CLS_BREAK;
				FN_XCH:   cls = CLS_XCH;
				default:  cls = CLS_NONE;
			endcase
		end
		return cls;
	endfunction

	function automatic int instr_length(instr_class_t cls);
		int n;
		case (cls)
			CLS_NONE:            n = 0;
			CLS_ARITH, CLS_XCH:  n = 2;
			CLS_SHIFT:           n = 3;
			default:             n = 1; // single execute state
		endcase
		return 1 + `CU_FETCH_WAIT + 2 + n;
	endfunction

	function automatic ctrl_en_t expect_en(cu_state_t s);
		ctrl_en_t e;
		e = '0;
		case (s)
			RESET, WRITE_ARITH, SHIFT_WRITE, MFHI, MFLO, SLT, XCH_1, XCH_2: e.reg_write = 1'b1;
			FETCH:    e.ir_write = 1'b1;
			FETCH_2, JR, RTE, BREAK: e.pc_write = 1'b1;
			DECODE: begin
				e.a_load = 1'b1;
				e.b_load = 1'b1;
				e.alu_out_load = 1'b1;
				e.xch_load = 1'b1;
			end
			ALU_EXEC: e.alu_out_load = 1'b1;
			default:  e = '0;
		endcase
		return e;
	endfunction

	function automatic ctrl_sel_t expect_sel(cu_state_t s, funct_t fn);
		ctrl_sel_t c;
		logic var_shift;
		c = '0;
		var_shift = (fn == FN_SLLV) || (fn == FN_SRAV);
		case (s)
			RESET: begin
				c.reg_dst = STACK_PTR;
				c.wb_src = RESET_VALUE;
			end
			FETCH, FETCH_2: begin
				c.alu_a = PC;
				c.alu_b = FOUR;
				c.alu_op = ALU_ADD;
			end
			DECODE: begin
				c.alu_a = PC;
				c.alu_b = OFFSET;
				c.alu_op = ALU_ADD;
			end
			ALU_EXEC: begin
				c.alu_a = REG_A;
				c.alu_b = REG_B;
				c.alu_op = (fn == FN_AND) ? ALU_AND : ((fn == FN_SUB) ? ALU_SUB : ALU_ADD);
			end
			SHIFT_LOAD, SHIFT_RUN: begin
				if (var_shift) begin
					c.shamt_sel = RS_VALUE;
					c.shift_in = RT_ALT;
				end
				if (s == SHIFT_LOAD) c.shift_op = SH_LOAD;
				else if (fn == FN_SLL || fn == FN_SLLV) c.shift_op = SH_LEFT;
				else if (fn == FN_SRL) c.shift_op = SH_RIGHT_LOGIC;
				else c.shift_op = SH_RIGHT_ARITH;
			end
			WRITE_ARITH, SHIFT_WRITE, MFHI, MFLO, SLT: begin
				c.reg_dst = RD;
				case (s)
					WRITE_ARITH: c.wb_src = ALU_OUT;
					SHIFT_WRITE: c.wb_src = SHIFTER;
					MFHI:        c.wb_src = HI;
					MFLO:        c.wb_src = LO;
					default: begin
						c.wb_src = LT_FLAG;
						c.alu_a = REG_A;
						c.alu_b = REG_B;
						c.alu_op = ALU_LESS;
					end
				endcase
			end
			JR: begin
				c.alu_a = REG_A;
				c.alu_op = ALU_LOAD;
			end
			RTE:   c.pc_src = EPC;
			BREAK: begin
				c.alu_a = PC;
				c.alu_b = FOUR;
				c.alu_op = ALU_SUB;
			end
			XCH_1: begin
				c.reg_dst = RS;
				c.wb_src = RT_VALUE;
			end
			XCH_2: begin
				c.reg_dst = RT;
				c.wb_src = XCH_REG;
			end
			default: c = '0;
		endcase
		return c;
	endfunction

	task automatic check_state(cu_state_t got, cu_state_t exp, string msg);
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t: %s state %s, expected %s", $time, msg, got.name(), exp.name());
		end
	endtask

	task automatic check_sel(ctrl_sel_t got, ctrl_sel_t exp, string msg);
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t: %s sel %h, expected %h", $time, msg, got, exp);
		end
	endtask

	task automatic check_en(ctrl_en_t got, ctrl_en_t exp, string msg);
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t: %s en %b, expected %b", $time, msg, got, exp);
		end
	endtask

	task automatic check_cycles(int got, int exp, string msg);
		if (got != exp) begin
			errors++;
			$display("FAILED at %0t: %s took %0d cycles, expected %0d", $time, msg, got, exp);
		end
	endtask

	// starts at the negedge of the first FETCH cycle, ends at the next one
	task automatic run_instr(string name, opcode_t op, funct_t fn);
		cu_state_t exp_q[$];
		instr_class_t cls;
		int start;
		int wait_cycles;
		string msg;
		cls = class_of(op, fn);
		repeat (`CU_FETCH_WAIT) exp_q.push_back(FETCH);
		exp_q.push_back(FETCH_2);
		exp_q.push_back(DECODE);
		case (cls)
			CLS_ARITH: begin
				exp_q.push_back(ALU_EXEC);
				exp_q.push_back(WRITE_ARITH);
			end
			CLS_SHIFT: begin
				exp_q.push_back(SHIFT_LOAD);
				exp_q.push_back(SHIFT_RUN);
				exp_q.push_back(SHIFT_WRITE);
			end
			CLS_MFHI:  exp_q.push_back(MFHI);
			CLS_MFLO:  exp_q.push_back(MFLO);
			CLS_SLT:   exp_q.push_back(SLT);
			CLS_JR:    exp_q.push_back(JR);
			CLS_RTE:   exp_q.push_back(RTE);
			CLS_BREAK: exp_q.push_back(BREAK);
			CLS_XCH: begin
				exp_q.push_back(XCH_1);
				exp_q.push_back(XCH_2);
			end
			default: ;
		endcase
		exp_q.push_back(FINAL);
		start = cycle;
		for (int i = 0; i < exp_q.size(); i++) begin
			if (i > 0) begin
				@(posedge clock);
				if (i == 1) begin
					opcode <= op; // decoded only from DECODE on
					funct <= fn;
				end
				@(negedge clock);
			end
			msg = $sformatf("%s in %s:", name, exp_q[i].name());
			check_state(state, exp_q[i], msg);
			check_sel(sel, expect_sel(exp_q[i], fn), msg);
			check_en(en, expect_en(exp_q[i]), msg);
		end
		wait_cycles = 0;
		do begin
			@(posedge clock);
			@(negedge clock);
			wait_cycles++;
		end while (state != FETCH && wait_cycles < 8); // follow the DUT back to FETCH
		check_state(state, FETCH, {name, " after FINAL:"});
		check_cycles(cycle - start, instr_length(cls), name);
	endtask

	task automatic finish_test(string name, int errors_before);
		if (errors == errors_before) begin
			tests_passed++;
			$display("test %s: pass", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d mismatches", name, errors - errors_before);
		end
	endtask

	task automatic test_reset_fetch();
		int e0;
		e0 = errors;
		@(negedge clock);
		check_state(state, RESET, "after reset:");
		check_sel(sel, expect_sel(RESET, funct), "after reset:");
		check_en(en, expect_en(RESET), "after reset:");
		@(posedge clock);
		@(negedge clock);
		run_instr("LW opcode", 6'h23, FN_ADD); // not R-type, full fetch path
		finish_test("reset and fetch", e0);
	endtask

	task automatic test_arith();
		int e0;
		e0 = errors;
		run_instr("ADD", `CU_OP_RTYPE, FN_ADD);
		run_instr("AND", `CU_OP_RTYPE, FN_AND);
		run_instr("SUB", `CU_OP_RTYPE, FN_SUB);
		finish_test("arithmetic", e0);
	endtask

	task automatic test_shifts();
		int e0;
		e0 = errors;
		run_instr("SLL", `CU_OP_RTYPE, FN_SLL);
		run_instr("SRL", `CU_OP_RTYPE, FN_SRL);
		run_instr("SRA", `CU_OP_RTYPE, FN_SRA);
		run_instr("SLLV", `CU_OP_RTYPE, FN_SLLV);
		run_instr("SRAV", `CU_OP_RTYPE, FN_SRAV);
		finish_test("shifts", e0);
	endtask

	task automatic test_single_cycle();
		int e0;
		e0 = errors;
		run_instr("MFHI", `CU_OP_RTYPE, FN_MFHI);
		run_instr("MFLO", `CU_OP_RTYPE, FN_MFLO);
		run_instr("SLT", `CU_OP_RTYPE, FN_SLT);
		run_instr("JR", `CU_OP_RTYPE, FN_JR);
		run_instr("RTE", `CU_OP_RTYPE, FN_RTE);
		run_instr("BREAK", `CU_OP_RTYPE, FN_BREAK);
		finish_test("single-cycle", e0);
	endtask

	task automatic test_exchange_unknown();
		int e0;
		funct_t rnd;
		e0 = errors;
		rnd = FN_ADD;
		run_instr("XCH", `CU_OP_RTYPE, FN_XCH);
		run_instr("BEQ opcode", 6'h04, FN_SLL); // shift code under a non R-type opcode
		for (int k = 0; k < 64; k++) begin
			rnd = funct_t'($random(seed));
			if (!(rnd inside {FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_XCH, FN_SRAV, FN_JR,
				FN_BREAK, FN_MFHI, FN_MFLO, FN_RTE, FN_ADD, FN_SUB, FN_AND, FN_SLT})) break;
		end
		run_instr($sformatf("funct %h", rnd), `CU_OP_RTYPE, rnd);
		finish_test("exchange and unknown codes", e0);
	endtask

	initial begin
		reset = 1'b1;
		opcode = '0;
		funct = '0;
		repeat (2) @(posedge clock);
		reset <= 1'b0;
		test_reset_fetch();
		test_arith();
		test_shifts();
		test_single_cycle();
		test_exchange_unknown();
		$display("tests passed: %0d, tests failed: %0d, mismatches: %0d",
			tests_passed, tests_failed, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// ==== list.f ====
+incdir+verilog
verilog/cu_pkg.sv
verilog/instr_decoder.sv
verilog/cu_sequencer.sv
verilog/control_word_gen.sv
verilog/control_unit.sv
sim/tb_control_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the control unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ns --top-module tb_control_unit -f list.f \
	&& ./obj_dir/Vtb_control_unit 2>&1 | tee sim.log \
	|| { echo "build or simulation did not run"; exit 1; }

grep -q "Test failures found" sim.log \
	&& { echo "simulation reported failures"; exit 1; } \
	|| { echo "simulation clean"; exit 0; }
